/* common/core_pkg.sv */
`default_nettype none

package core_pkg;

    // ------------------------------------------------------------
    // Widths with a meaning of their own
    // ------------------------------------------------------------
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_index_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // Major opcodes of the kept instruction groups
    localparam opcode_t OP_IMM = 7'b001_0011;
    localparam opcode_t OP     = 7'b011_0011;
    localparam opcode_t LUI    = 7'b011_0111;
    localparam opcode_t AUIPC  = 7'b001_0111;

    // ALU operations, shared by OP and OP_IMM
    localparam funct3_t FUNCT3_ADD  = 3'b000;
    localparam funct3_t FUNCT3_SLL  = 3'b001;
    localparam funct3_t FUNCT3_SLT  = 3'b010;
    localparam funct3_t FUNCT3_SLTU = 3'b011;
    localparam funct3_t FUNCT3_XOR  = 3'b100;
    localparam funct3_t FUNCT3_SR   = 3'b101;
    localparam funct3_t FUNCT3_OR   = 3'b110;
    localparam funct3_t FUNCT3_AND  = 3'b111;

    // funct7 bit 5, selects SUB over ADD and SRA over SRL
    localparam int ALT_BIT_POSITION = 30;

    // ADDI x0, x0, 0
    localparam word_t NOP_INSTRUCTION = 32'h0000_0013;

    // ------------------------------------------------------------
    // Stage payloads
    // ------------------------------------------------------------

    // Decoder output, one instruction
    typedef struct packed {
        opcode_t    opcode;
        funct3_t    funct3;
        logic       alt;
        reg_index_t rs1;
        reg_index_t rs2;
        reg_index_t rd;
        word_t      immediate;
        logic       use_immediate;
        logic       write_enable;
    } decode_t;

    // Decode to execute register
    typedef struct packed {
        decode_t decoded;
        word_t   pc;
        word_t   operand_1;
        word_t   operand_2;
    } exec_t;

    // Register write in flight
    // Also the forwarding source and the retire report
    typedef struct packed {
        logic       valid;
        reg_index_t rd;
        word_t      data;
    } retire_t;

endpackage

`default_nettype wire

/* decode/instruction_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_decoder
    import core_pkg::*;
(
    input  word_t   instruction,
    output decode_t decoded
);

    // ------------------------------------------------------------
    // Opcode classes
    // ------------------------------------------------------------
    opcode_t opcode;
    logic    is_op;
    logic    is_op_imm;
    logic    is_upper;
    logic    kept_opcode;

    word_t   i_immediate;
    word_t   u_immediate;

    assign opcode    = instruction[6:0];
    assign is_op     = (opcode == OP);
    assign is_op_imm = (opcode == OP_IMM);

    // LUI and AUIPC share the U-type layout
    assign is_upper  = (opcode == LUI) || (opcode == AUIPC);

    // Anything outside these leaves as a bubble
    assign kept_opcode = is_op || is_op_imm || is_upper;

    // ------------------------------------------------------------
    // Immediates
    // ------------------------------------------------------------

    // I-type, sign-extended from bit 31
    // For shifts the low five bits are the shift amount
    assign i_immediate = {{20{instruction[31]}}, instruction[31:20]};

    // U-type, upper twenty bits with zero low part
    assign u_immediate = {instruction[31:12], 12'h000};

    // ------------------------------------------------------------
    // Field split and write intent
    // ------------------------------------------------------------
    always_comb
    begin
        decoded.opcode = opcode;
        decoded.funct3 = instruction[14:12];
        decoded.alt    = instruction[ALT_BIT_POSITION];
        decoded.rd     = instruction[11:7];

        // Source fields only where the format has them
        // Keeps forwarding from matching on immediate bits
        if (is_upper)
            decoded.rs1 = '0;
        else
            decoded.rs1 = instruction[19:15];

        if (is_op)
            decoded.rs2 = instruction[24:20];
        else
            decoded.rs2 = '0;

        // Immediate by format
        if (is_upper)
            decoded.immediate = u_immediate;
        else if (is_op_imm)
            decoded.immediate = i_immediate;
        else
            decoded.immediate = '0;

        decoded.use_immediate = is_op_imm || is_upper;

        // No write for x0, nor for unknown opcodes
        decoded.write_enable = kept_opcode && (decoded.rd != '0);
    end

endmodule

`default_nettype wire

/* source/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file
    import core_pkg::*;
(
    input  logic       CLK,
    input  logic       reset,
    input  reg_index_t read_index_1,
    input  reg_index_t read_index_2,
    output word_t      read_data_1,
    output word_t      read_data_2,
    input  retire_t    write_port
);

    // 32 architectural registers, entry zero stays zero
    word_t registers [32];

    // Write at the end of the write-back cycle
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                registers[i] <= '0;
        end
        else if (write_port.valid && (write_port.rd != '0))
        begin
            registers[write_port.rd] <= write_port.data;
        end
    end

    // Combinational reads, old value during a same-cycle write
    // x0 hard-wired to zero
    assign read_data_1 = (read_index_1 == '0) ? '0 : registers[read_index_1];
    assign read_data_2 = (read_index_2 == '0) ? '0 : registers[read_index_2];

endmodule

`default_nettype wire

/* execute/arithmetic_logic_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module arithmetic_logic_unit
    import core_pkg::*;
(
    input  exec_t   operation,
    output retire_t result
);

    word_t      operand_a;
    word_t      operand_b;
    logic [4:0] shift_amount;
    logic       subtract;
    word_t      alu_value;

    // ------------------------------------------------------------
    // Operand selection
    // ------------------------------------------------------------
    assign operand_a    = operation.operand_1;
    assign operand_b    = operation.decoded.use_immediate ? operation.decoded.immediate
                                                          : operation.operand_2;
    assign shift_amount = operand_b[4:0];

    // SUB exists only in the register-register form
    assign subtract = (operation.decoded.opcode == OP) && operation.decoded.alt;

    // ------------------------------------------------------------
    // Result by opcode and funct3
    // ------------------------------------------------------------
    always_comb
    begin
        case (operation.decoded.opcode)
            LUI   : alu_value = operation.decoded.immediate;
            AUIPC : alu_value = operation.pc + operation.decoded.immediate;
            OP, OP_IMM :
            begin
                case (operation.decoded.funct3)
                    FUNCT3_ADD  : alu_value = subtract ? operand_a - operand_b
                                                       : operand_a + operand_b;
                    FUNCT3_SLL  : alu_value = operand_a << shift_amount;
                    FUNCT3_SLT  : alu_value = word_t'($signed(operand_a) < $signed(operand_b));
                    FUNCT3_SLTU : alu_value = word_t'(operand_a < operand_b);
                    FUNCT3_XOR  : alu_value = operand_a ^ operand_b;
                    // Arithmetic shift for SRA and SRAI
                    FUNCT3_SR   : alu_value = operation.decoded.alt
                                            ? word_t'($signed(operand_a) >>> shift_amount)
                                            : operand_a >> shift_amount;
                    FUNCT3_OR   : alu_value = operand_a | operand_b;
                    FUNCT3_AND  : alu_value = operand_a & operand_b;
                    default     : alu_value = '0;
                endcase
            end
            // Bubbles carry no value
            default : alu_value = '0;
        endcase
    end

    // Write intent already excludes x0 and unknown opcodes
    assign result.valid = operation.decoded.write_enable;
    assign result.rd    = operation.decoded.rd;
    assign result.data  = alu_value;

endmodule

`default_nettype wire

/* source/forward_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module forward_unit
    import core_pkg::*;
(
    input  reg_index_t source_index,
    input  retire_t    execute_write,
    input  retire_t    memory_write,
    input  retire_t    writeback_write,
    output logic       forward_hit,
    output word_t      forward_data
);

    logic execute_match;
    logic memory_match;
    logic writeback_match;

    // Valid is never set for rd zero, so x0 cannot match
    assign execute_match   = execute_write.valid   && (execute_write.rd   == source_index);
    assign memory_match    = memory_write.valid    && (memory_write.rd    == source_index);
    assign writeback_match = writeback_write.valid && (writeback_write.rd == source_index);

    assign forward_hit = execute_match || memory_match || writeback_match;

    // ------------------------------------------------------------
    // Youngest write wins
    // ------------------------------------------------------------
    always_comb
    begin
        if (execute_match)
            forward_data = execute_write.data;
        else if (memory_match)
            forward_data = memory_write.data;
        else if (writeback_match)
            forward_data = writeback_write.data;
        else
            forward_data = '0;   // unused without a hit
    end

endmodule

`default_nettype wire

/* source/core_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module core_pipeline
    import core_pkg::*;
#(
    parameter word_t RESET_ADDRESS = 32'h0000_0000
)
(
    input  logic    CLK,
    input  logic    reset,
    input  word_t   instruction,
    input  logic    instruction_valid,
    output retire_t retire
);

    // ------------------------------------------------------------
    // Fetch capture
    // ------------------------------------------------------------
    word_t pc;
    word_t decode_instruction;
    word_t decode_pc;

    // PC advances only on accepted instructions
    // Idle cycles enter the pipe as NOPs
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            pc                 <= RESET_ADDRESS;
            decode_instruction <= NOP_INSTRUCTION;
        end
        else if (instruction_valid)
        begin
            pc                 <= pc + 32'd4;
            decode_instruction <= instruction;
        end
        else
        begin
            decode_instruction <= NOP_INSTRUCTION;
        end
    end

    // PC of the instruction now in decode
    always_ff @(posedge CLK)
    begin
        decode_pc <= pc;
    end

    // ------------------------------------------------------------
    // Decode, register read and forwarding
    // ------------------------------------------------------------
    decode_t decoded;
    word_t   rf_data_1;
    word_t   rf_data_2;
    logic    forward_hit_1;
    logic    forward_hit_2;
    word_t   forward_data_1;
    word_t   forward_data_2;
    retire_t execute_result;
    retire_t memory_reg;
    retire_t writeback_reg;
    exec_t   exec_next;
    exec_t   exec_reg;

    instruction_decoder decoder
    (
        .instruction (decode_instruction),
        .decoded     (decoded)
    );

    // Write port fed from write-back
    register_file registers
    (
        .CLK          (CLK),
        .reset        (reset),
        .read_index_1 (decoded.rs1),
        .read_index_2 (decoded.rs2),
        .read_data_1  (rf_data_1),
        .read_data_2  (rf_data_2),
        .write_port   (writeback_reg)
    );

    // One forwarding unit per source operand
    forward_unit forward_source_1
    (
        .source_index    (decoded.rs1),
        .execute_write   (execute_result),
        .memory_write    (memory_reg),
        .writeback_write (writeback_reg),
        .forward_hit     (forward_hit_1),
        .forward_data    (forward_data_1)
    );

    forward_unit forward_source_2
    (
        .source_index    (decoded.rs2),
        .execute_write   (execute_result),
        .memory_write    (memory_reg),
        .writeback_write (writeback_reg),
        .forward_hit     (forward_hit_2),
        .forward_data    (forward_data_2)
    );

    // Forwarded value takes priority over the register file
    always_comb
    begin
        exec_next.decoded   = decoded;
        exec_next.pc        = decode_pc;
        exec_next.operand_1 = forward_hit_1 ? forward_data_1 : rf_data_1;
        exec_next.operand_2 = forward_hit_2 ? forward_data_2 : rf_data_2;
    end

    // ------------------------------------------------------------
    // Execute, memory and write-back registers
    // ------------------------------------------------------------

    // Reset only drops the write intent, payload may hold
    always_ff @(posedge CLK)
    begin
        if (reset)
            exec_reg.decoded.write_enable <= 1'b0;
        else
            exec_reg <= exec_next;
    end

    arithmetic_logic_unit alu
    (
        .operation (exec_reg),
        .result    (execute_result)
    );

    // Memory stage only carries the result forward
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            memory_reg.valid    <= 1'b0;
            writeback_reg.valid <= 1'b0;
        end
        else
        begin
            memory_reg    <= execute_result;
            writeback_reg <= memory_reg;
        end
    end

    // Register write in progress is the retire report
    assign retire = writeback_reg;

endmodule

`default_nettype wire

/* verification/core_model.svh */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// Architectural state of the kept RV32I subset
word_t model_regs [32];
word_t model_pc;

task automatic model_reset();
    for (int i = 0; i < 32; i++)
        model_regs[i] = '0;
    model_pc = RESET_ADDRESS;
endtask

// One accepted instruction in program order
// Reports whether it writes a register and the value
task automatic model_execute(input word_t instr, output logic writes,
                             output reg_index_t rd, output word_t value);
    opcode_t opc;
    funct3_t f3;
    word_t   a;
    word_t   b;
    opc    = instr[6:0];
    f3     = instr[14:12];
    rd     = instr[11:7];
    a      = model_regs[instr[19:15]];
    writes = 1'b1;
    value  = '0;
    if (opc == LUI)
        value = {instr[31:12], 12'h000};
    else if (opc == AUIPC)
        value = model_pc + {instr[31:12], 12'h000};
    else if ((opc == OP) || (opc == OP_IMM))
    begin
        // Register operand or sign-extended I-type immediate
        b = (opc == OP) ? model_regs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
        if (f3 == FUNCT3_ADD)
            value = ((opc == OP) && instr[30]) ? a - b : a + b;
        else if (f3 == FUNCT3_SLL)
            value = a << b[4:0];
        else if (f3 == FUNCT3_SLT)
            value = {31'd0, ($signed(a) < $signed(b))};
        else if (f3 == FUNCT3_SLTU)
            value = {31'd0, (a < b)};
        else if (f3 == FUNCT3_XOR)
            value = a ^ b;
        else if (f3 == FUNCT3_SR)
            value = instr[30] ? word_t'($signed(a) >>> b[4:0]) : (a >> b[4:0]);
        else if (f3 == FUNCT3_OR)
            value = a | b;
        else
            value = a & b;
    end
    else
        writes = 1'b0;
    // x0 never changes
    if (rd == 5'd0)
        writes = 1'b0;
    if (writes)
        model_regs[rd] = value;
    model_pc = model_pc + 32'd4;
endtask

`endif

/* verification/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb
    import core_pkg::*;
();

    localparam word_t RESET_ADDRESS  = 32'h0000_1000;
    localparam int    SLOTS_PER_TEST = 64;
    // Four random tests plus the quiet cycles after reset
    localparam int    TOTAL_SLOTS    = SLOTS_PER_TEST * 4 + 4;
    localparam int    WATCHDOG_NS    = 8 * (TOTAL_SLOTS + 20) * 2;

    logic    CLK;
    logic    reset;
    word_t   instruction;
    logic    instruction_valid;
    retire_t retire;

    // Expected retires with the cycle each one is due
    retire_t expect_queue [$];
    int      due_queue [$];
    int      edge_count;
    int      error_count;
    int      check_count;
    int      test_errors;
    int      test_checks;
    int      unexpected_count;
    string   current_test;
    word_t   rng_state;

    `include "core_model.svh"

    core_pipeline #(.RESET_ADDRESS (RESET_ADDRESS)) UUT
    (
        .CLK               (CLK),
        .reset             (reset),
        .instruction       (instruction),
        .instruction_valid (instruction_valid),
        .retire            (retire)
    );

    always #4 CLK = ~CLK;

    always @(posedge CLK)
        edge_count <= edge_count + 1;

    // ------------------------------------------------------------
    // Stimulus generators
    // ------------------------------------------------------------
    function automatic word_t next_random();
        word_t x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Registers x0 to x7 only, dense dependencies
    function automatic word_t make_register_op();
        word_t r;
        logic  alt;
        r   = next_random();
        alt = r[3] && ((r[2:0] == FUNCT3_ADD) || (r[2:0] == FUNCT3_SR));
        return {1'b0, alt, 5'd0, 2'b00, r[6:4], 2'b00, r[9:7], r[2:0], 2'b00, r[12:10], OP};
    endfunction

    function automatic word_t make_immediate_op();
        word_t       r;
        logic [11:0] imm;
        r   = next_random();
        imm = r[31:20];
        // Shifts take a five bit amount, SRAI adds the alternate bit
        if (r[2:0] == FUNCT3_SLL)
            imm = {7'd0, r[24:20]};
        else if (r[2:0] == FUNCT3_SR)
            imm = {1'b0, r[3], 5'd0, r[24:20]};
        return {imm, 2'b00, r[6:4], r[2:0], 2'b00, r[9:7], OP_IMM};
    endfunction

    function automatic word_t make_upper_op();
        word_t r;
        r = next_random();
        return {r[31:12], 2'b00, r[3:1], r[0] ? LUI : AUIPC};
    endfunction

    // Illegal opcodes, x0 targets and x0 sources
    function automatic word_t make_bubble_op();
        word_t r;
        r = next_random();
        if (r[1:0] == 2'd0)
            return {r[31:9], 2'b11, 7'b000_0011 | {r[3:2], 5'd0}};
        else if (r[1:0] == 2'd1)
            return make_register_op() & ~32'h0000_0F80;
        else if (r[1:0] == 2'd2)
            return make_immediate_op() & ~32'h0000_0F80;
        return make_register_op() & ~32'h000F_8000;
    endfunction

    // ------------------------------------------------------------
    // Drive, scoreboard and test bookkeeping
    // ------------------------------------------------------------
    task automatic count_error();
        error_count++;
        test_errors++;
    endtask

    // One slot of the instruction port, then on to the next cycle
    task automatic drive_slot(input word_t word, input logic valid);
        logic       writes;
        reg_index_t rd;
        word_t      value;
        instruction       = word;
        instruction_valid = valid;
        if (valid)
        begin
            model_execute(word, writes, rd, value);
            if (writes)
            begin
                expect_queue.push_back({1'b1, rd, value});
                // Captured at the next edge, on retire three edges later
                due_queue.push_back(edge_count + 4);
            end
        end
        @(posedge CLK);
        #1;
    endtask

    always @(negedge CLK)
    begin : scoreboard
        retire_t expected;
        int      due_cycle;
        if (!reset && retire.valid)
        begin
            test_checks++;
            check_count++;
            assert (expect_queue.size() != 0)
            else
            begin
                $display("Unexpected retire to x%0d in test %s", retire.rd, current_test);
                unexpected_count++;
                count_error();
            end
            if (expect_queue.size() != 0)
            begin
                expected  = expect_queue.pop_front();
                due_cycle = due_queue.pop_front();
                assert ((retire.rd == expected.rd) && (retire.data == expected.data))
                else
                begin
                    $display("FAIL %s expected x%0d=%08h actual x%0d=%08h", current_test,
                             expected.rd, expected.data, retire.rd, retire.data);
                    count_error();
                end
                assert (edge_count == due_cycle)
                else
                begin
                    $display("Retire of x%0d in test %s came at cycle %0d, due at cycle %0d",
                             retire.rd, current_test, edge_count, due_cycle);
                    count_error();
                end
            end
        end
    end

    task automatic begin_test(input string name);
        current_test = name;
        test_errors  = 0;
        test_checks  = 0;
    endtask

    // Idle until every expected retire has arrived
    task automatic end_test();
        for (int i = 0; (i < 8) && (expect_queue.size() != 0); i++)
            drive_slot(NOP_INSTRUCTION, 1'b0);
        assert (expect_queue.size() == 0)
        else
        begin
            $display("Test %s ended with %0d retires missing", current_test, expect_queue.size());
            count_error();
        end
        $display("Test %s finished: %0d checks, %0d errors", current_test, test_checks, test_errors);
    endtask

    // Kind 0 register ops, 1 immediates, 2 upper, 3 bubbles
    task automatic run_random_test(input string name, input int kind);
        word_t r;
        word_t word;
        begin_test(name);
        for (int slot = 0; slot < SLOTS_PER_TEST; slot++)
        begin
            r    = next_random();
            word = make_register_op();
            if ((kind == 1) && (r[5:3] < 3'd6))
                word = make_immediate_op();
            else if ((kind == 2) && (r[5:3] < 3'd4))
                word = make_upper_op();
            else if ((kind == 2) || ((kind == 3) && (r[5:3] >= 3'd4)))
                word = make_immediate_op();
            else if (kind == 3)
                word = make_bubble_op();
            // About one slot in eight idles, with junk on the port
            if (r[2:0] == 3'b000)
                drive_slot(next_random(), 1'b0);
            else
                drive_slot(word, 1'b1);
        end
        end_test();
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial
    begin
        CLK               = 1'b0;
        reset             = 1'b1;
        instruction       = NOP_INSTRUCTION;
        instruction_valid = 1'b0;
        rng_state         = 32'd14827;
        edge_count        = 0;
        error_count       = 0;
        check_count       = 0;
        unexpected_count  = 0;
        current_test      = "reset";
        model_reset();
        repeat (2) @(posedge CLK);
        #1;
        reset = 1'b0;

        begin_test("reset_quiet");
        for (int i = 0; i < 4; i++)
        begin
            drive_slot(next_random(), 1'b0);
            test_checks++;
            check_count++;
            assert (retire.valid == 1'b0)
            else
            begin
                $display("FAIL reset_quiet expected valid=0 actual valid=%0b", retire.valid);
                count_error();
            end
        end
        end_test();

        run_random_test("dependent_register_ops", 0);
        run_random_test("immediate_ops", 1);
        run_random_test("upper_immediates", 2);
        run_random_test("bubbles_and_x0", 3);

        begin_test("drain_check");
        assert (unexpected_count == 0)
        else
        begin
            $display("Run saw %0d retires that no instruction asked for", unexpected_count);
            count_error();
        end
        end_test();

        $display("Totals: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // Run time bound from the number of slots
    initial
    begin
        #WATCHDOG_NS;
        $display("Watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+verification
common/core_pkg.sv
decode/instruction_decoder.sv
source/register_file.sv
execute/arithmetic_logic_unit.sv
source/forward_unit.sv
source/core_pipeline.sv
verification/core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -j 0 --top-module core_tb \
    -Mdir build/obj_dir -o core_tb_sim -f sim.f

build/obj_dir/core_tb_sim | tee build/sim.log

if grep -q "SIMULATION FAILED" build/sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation log is clean"
